/* include/mul_consts.svh */
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// Operand width of the multiply unit
// The Booth/Wallace tree is built for this width only
`define MUL_XLEN 32

// Edges from a sampled start to the finish pulse
`define MUL_LATENCY 3

// Destination tag carried alongside each multiply
`define MUL_TAG_W 5

`endif

/* verilog/rv32m_mul_pkg.sv */
package rv32m_mul_pkg;

	// How an operand is read by the multiplier
	typedef enum logic {
		UNSIGNED = 1'b0,
		SIGNED   = 1'b1
	} sign_type_t;

	// M extension multiply operations, in funct3 order
	typedef enum logic [1:0] {
		MUL_LO = 2'b00,
		MULH   = 2'b01,
		MULHSU = 2'b10,
		MULHU  = 2'b11
	} mul_op_t;

endpackage

/* verilog/mul_csa.sv */
`timescale 1ns/100ps

module mul_csa #(
	parameter int WIDTH = 64
) (
	input  logic [WIDTH-1:0] x,
	input  logic [WIDTH-1:0] y,
	input  logic [WIDTH-1:0] z,
	output logic [WIDTH-1:0] sum,
	output logic [WIDTH-1:0] cout
);

	// Bitwise full adder, carry moved up to its weight
	assign sum  = x ^ y ^ z;
	assign cout = ((x & y) | (y & z) | (x & z)) << 1;

endmodule

/* verilog/multiplier.sv */
`timescale 1ns/100ps

module multiplier (
	input  logic                            CLK,
	input  logic                            nRST,
	input  logic [31:0]                     multiplicand,
	input  logic [31:0]                     multiplier,
	input  rv32m_mul_pkg::sign_type_t [1:0] is_signed,
	input  logic                            start,
	output logic                            finished,
	output logic                            next_finished,
	output logic [63:0]                     product
);

	// Input registers
	logic [31:0] mcand_q;
	logic [31:0] mplier_q;
	rv32m_mul_pkg::sign_type_t [1:0] is_signed_q;

	// Stage 1 combinational
	logic [31:0] mcand_mag;
	logic [31:0] mplier_mag;
	logic        negate;
	logic [31:0] corr_word;
	logic [32:0] booth_in;
	logic [63:0] pos1;
	logic [63:0] pos2;
	logic [63:0] neg1;
	logic [63:0] neg2;
	logic [63:0] pp [16];

	// Partial product registers
	logic [63:0] pp_q [16];
	logic        negate_q1;
	logic [31:0] corr_q1;

	// Wallace tree nets
	logic [63:0] s [14];
	logic [63:0] c [14];

	// Midpoint registers after layer 2
	logic [63:0] s5_q, c5_q;
	logic [63:0] s6_q, c6_q;
	logic [63:0] s7_q, c7_q;
	logic [63:0] s4_q;
	logic [63:0] pp15_q;
	logic        negate_q2;
	logic [31:0] corr_q2;

	// Final adder
	logic [63:0] raw_sum;
	logic [63:0] corrected;

	// Start shift for finish pulses
	logic [2:0] start_sr;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mcand_q        <= '0;
			mplier_q       <= '0;
			is_signed_q[1] <= rv32m_mul_pkg::UNSIGNED;
			is_signed_q[0] <= rv32m_mul_pkg::UNSIGNED;
		end else if (start) begin
			mcand_q     <= multiplicand;
			mplier_q    <= multiplier;
			is_signed_q <= is_signed;
		end
	end

	// Work on magnitudes, sign restored in stage 3
	always_comb begin
		if (is_signed_q[1] == rv32m_mul_pkg::SIGNED && mcand_q[31])
			mcand_mag = ~mcand_q + 32'd1;
		else
			mcand_mag = mcand_q;
		if (is_signed_q[0] == rv32m_mul_pkg::SIGNED && mplier_q[31])
			mplier_mag = ~mplier_q + 32'd1;
		else
			mplier_mag = mplier_q;
	end

	assign negate = (is_signed_q[1] == rv32m_mul_pkg::SIGNED && mcand_q[31]) ^
		(is_signed_q[0] == rv32m_mul_pkg::SIGNED && mplier_q[31]);

	// Booth reads bit 31 as a sign, so a set top bit needs M added at 2^32
	assign corr_word = mplier_mag[31] ? mcand_mag : 32'd0;

	assign booth_in = {mplier_mag, 1'b0};
	assign pos1     = {32'd0, mcand_mag};
	assign pos2     = pos1 << 1;
	assign neg1     = ~pos1 + 64'd1;
	assign neg2     = ~pos2 + 64'd1;

	// Radix-4 recoding, one digit per bit pair
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			case (booth_in[2*i+2 -: 3])
				3'b001, 3'b010: pp[i] = pos1 << (2*i);
				3'b011:         pp[i] = pos2 << (2*i);
				3'b100:         pp[i] = neg2 << (2*i);
				3'b101, 3'b110: pp[i] = neg1 << (2*i);
				default:        pp[i] = '0;
			endcase
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 16; i++)
				pp_q[i] <= '0;
			negate_q1 <= 1'b0;
			corr_q1   <= '0;
		end else begin
			for (int i = 0; i < 16; i++)
				pp_q[i] <= pp[i];
			negate_q1 <= negate;
			corr_q1   <= corr_word;
		end
	end

	// Layer 1, pp 15 waits for layer 4
	mul_csa #(64) csa0 (.x(pp_q[0]), .y(pp_q[1]), .z(pp_q[2]), .sum(s[0]), .cout(c[0]));
	mul_csa #(64) csa1 (.x(pp_q[3]), .y(pp_q[4]), .z(pp_q[5]), .sum(s[1]), .cout(c[1]));
	mul_csa #(64) csa2 (.x(pp_q[6]), .y(pp_q[7]), .z(pp_q[8]), .sum(s[2]), .cout(c[2]));
	mul_csa #(64) csa3 (.x(pp_q[9]), .y(pp_q[10]), .z(pp_q[11]), .sum(s[3]), .cout(c[3]));
	mul_csa #(64) csa4 (.x(pp_q[12]), .y(pp_q[13]), .z(pp_q[14]), .sum(s[4]), .cout(c[4]));

	// Layer 2
	mul_csa #(64) csa5 (.x(s[0]), .y(c[0]), .z(c[1]), .sum(s[5]), .cout(c[5]));
	mul_csa #(64) csa6 (.x(s[1]), .y(s[2]), .z(c[2]), .sum(s[6]), .cout(c[6]));
	mul_csa #(64) csa7 (.x(s[3]), .y(c[3]), .z(c[4]), .sum(s[7]), .cout(c[7]));

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			s5_q      <= '0;
			c5_q      <= '0;
			s6_q      <= '0;
			c6_q      <= '0;
			s7_q      <= '0;
			c7_q      <= '0;
			s4_q      <= '0;
			pp15_q    <= '0;
			negate_q2 <= 1'b0;
			corr_q2   <= '0;
		end else begin
			s5_q      <= s[5];
			c5_q      <= c[5];
			s6_q      <= s[6];
			c6_q      <= c[6];
			s7_q      <= s[7];
			c7_q      <= c[7];
			s4_q      <= s[4];
			pp15_q    <= pp_q[15];
			negate_q2 <= negate_q1;
			corr_q2   <= corr_q1;
		end
	end

	// Layers 3 to 6 down to one sum and one carry
	mul_csa #(64) csa8 (.x(s5_q), .y(c5_q), .z(c6_q), .sum(s[8]), .cout(c[8]));
	mul_csa #(64) csa9 (.x(s6_q), .y(s7_q), .z(c7_q), .sum(s[9]), .cout(c[9]));
	mul_csa #(64) csa10 (.x(s[8]), .y(c[8]), .z(c[9]), .sum(s[10]), .cout(c[10]));
	mul_csa #(64) csa11 (.x(s[9]), .y(pp15_q), .z(s4_q), .sum(s[11]), .cout(c[11]));
	mul_csa #(64) csa12 (.x(s[10]), .y(c[10]), .z(c[11]), .sum(s[12]), .cout(c[12]));
	mul_csa #(64) csa13 (.x(s[12]), .y(c[12]), .z(s[11]), .sum(s[13]), .cout(c[13]));

	// Carry-propagate add, then top-bit correction and sign
	assign raw_sum   = s[13] + c[13];
	assign corrected = raw_sum + {corr_q2, 32'd0};
	assign product   = negate_q2 ? (~corrected + 64'd1) : corrected;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			start_sr <= '0;
		else
			start_sr <= {start_sr[1:0], start};
	end

	assign next_finished = start_sr[1];
	assign finished      = start_sr[2];

endmodule

/* verilog/mul_unit.sv */
`timescale 1ns/100ps

`include "mul_consts.svh"

module mul_unit (
	input  logic                        CLK,
	input  logic                        nRST,
	input  logic                        valid,
	input  rv32m_mul_pkg::mul_op_t      op,
	input  logic [`MUL_XLEN-1:0]        rs1,
	input  logic [`MUL_XLEN-1:0]        rs2,
	input  logic [`MUL_TAG_W-1:0]       tag,
	output logic                        done,
	output logic                        next_done,
	output logic [`MUL_TAG_W-1:0]       done_tag,
	output logic [`MUL_TAG_W-1:0]       next_tag,
	output logic [`MUL_XLEN-1:0]        result
);

	rv32m_mul_pkg::sign_type_t [1:0] op_signed;
	rv32m_mul_pkg::mul_op_t op_q1, op_q2, op_q3;
	logic [`MUL_TAG_W-1:0] tag_q1, tag_q2, tag_q3;
	logic [2*`MUL_XLEN-1:0] product;
	logic finished;
	logic next_finished;

	// Entry 1 is rs1, entry 0 is rs2
	// MUL_LO runs unsigned since the low word is sign-independent
	always_comb begin
		op_signed[1] = rv32m_mul_pkg::UNSIGNED;
		op_signed[0] = rv32m_mul_pkg::UNSIGNED;
		if (op == rv32m_mul_pkg::MULH || op == rv32m_mul_pkg::MULHSU)
			op_signed[1] = rv32m_mul_pkg::SIGNED;
		if (op == rv32m_mul_pkg::MULH)
			op_signed[0] = rv32m_mul_pkg::SIGNED;
	end

	multiplier u_multiplier (
		.CLK          (CLK),
		.nRST         (nRST),
		.multiplicand (rs1),
		.multiplier   (rs2),
		.is_signed    (op_signed),
		.start        (valid),
		.finished     (finished),
		.next_finished(next_finished),
		.product      (product)
	);

	// Op and tag follow the multiplier stages
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			op_q1  <= rv32m_mul_pkg::MUL_LO;
			op_q2  <= rv32m_mul_pkg::MUL_LO;
			op_q3  <= rv32m_mul_pkg::MUL_LO;
			tag_q1 <= '0;
			tag_q2 <= '0;
			tag_q3 <= '0;
		end else begin
			if (valid) begin
				op_q1  <= op;
				tag_q1 <= tag;
			end
			op_q2  <= op_q1;
			op_q3  <= op_q2;
			tag_q2 <= tag_q1;
			tag_q3 <= tag_q2;
		end
	end

	// Low word for MUL, high word for the rest
	assign result = (op_q3 == rv32m_mul_pkg::MUL_LO) ?
		product[`MUL_XLEN-1:0] : product[2*`MUL_XLEN-1:`MUL_XLEN];

	assign done      = finished;
	assign done_tag  = tag_q3;
	assign next_done = next_finished;
	// Multiply in the middle stage finishes on the next cycle
	assign next_tag  = tag_q2;

endmodule

/* dv/mul_unit_tb.sv */
`timescale 1ns/100ps

`include "mul_consts.svh"

module mul_unit_tb;

	localparam int MAX_CYCLES = 400;
	localparam int STREAM_LEN = 40;

	logic CLK;
	logic nRST;
	logic valid;
	rv32m_mul_pkg::mul_op_t op;
	logic [`MUL_XLEN-1:0] rs1;
	logic [`MUL_XLEN-1:0] rs2;
	logic [`MUL_TAG_W-1:0] tag;
	logic done;
	logic next_done;
	logic [`MUL_TAG_W-1:0] done_tag;
	logic [`MUL_TAG_W-1:0] next_tag;
	logic [`MUL_XLEN-1:0] result;

	string cur_test;
	int cycle_count;

	mul_unit UUT (
		.CLK      (CLK),
		.nRST     (nRST),
		.valid    (valid),
		.op       (op),
		.rs1      (rs1),
		.rs2      (rs2),
		.tag      (tag),
		.done     (done),
		.next_done(next_done),
		.done_tag (done_tag),
		.next_tag (next_tag),
		.result   (result)
	);

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "Run stopped");
	endtask

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
			stop_with_failure("Timeout: the run went past its cycle limit");
	end

	task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
		string line;
		if (exp !== act) begin
			line = $sformatf("ERROR %s (%s): expected %h actual %h", cur_test, what, exp, act);
			stop_with_failure(line);
		end
	endtask

	// Full 64-bit product of the extended operands as the ISA defines it
	function automatic logic [31:0] model_result(input rv32m_mul_pkg::mul_op_t o,
		input logic [31:0] a, input logic [31:0] b);
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] p;
		ea = {32'd0, a};
		eb = {32'd0, b};
		if (o == rv32m_mul_pkg::MULH || o == rv32m_mul_pkg::MULHSU)
			ea = {{32{a[31]}}, a};
		if (o == rv32m_mul_pkg::MULH)
			eb = {{32{b[31]}}, b};
		p = ea * eb;
		return (o == rv32m_mul_pkg::MUL_LO) ? p[31:0] : p[63:32];
	endfunction

	// One multiply alone in the pipeline and watched until done
	task automatic issue_single(input rv32m_mul_pkg::mul_op_t o, input logic [31:0] a,
		input logic [31:0] b, input logic [`MUL_TAG_W-1:0] t);
		int n;
		logic seen_next;
		logic [31:0] exp;
		exp = model_result(o, a, b);
		seen_next = 1'b0;
		@(negedge CLK);
		valid = 1'b1;
		op = o;
		rs1 = a;
		rs2 = b;
		tag = t;
		@(negedge CLK);
		valid = 1'b0;
		n = 1;
		while (!done && n < 8) begin
			if (next_done) begin
				check("next_done cycle", `MUL_LATENCY - 1, n);
				check("next_tag", t, next_tag);
				seen_next = 1'b1;
			end
			@(negedge CLK);
			n++;
		end
		if (!done)
			stop_with_failure($sformatf("%s: done never came for tag %0d", cur_test, t));
		check("done cycle", `MUL_LATENCY, n);
		check("next_done seen", 1, seen_next);
		check("done_tag", t, done_tag);
		check("result", exp, result);
	endtask

	task automatic idle_quiet();
		cur_test = "idle";
		valid = 1'b0;
		repeat (6) begin
			@(negedge CLK);
			check("done", 0, done);
			check("next_done", 0, next_done);
		end
	endtask

	task automatic low_word_corners();
		cur_test = "mul_lo";
		issue_single(rv32m_mul_pkg::MUL_LO, 32'h0000_0000, 32'h0000_0005, 5'd1);
		issue_single(rv32m_mul_pkg::MUL_LO, 32'h0000_0001, 32'hffff_ffff, 5'd2);
		issue_single(rv32m_mul_pkg::MUL_LO, 32'hffff_ffff, 32'hffff_ffff, 5'd3);
		issue_single(rv32m_mul_pkg::MUL_LO, 32'h8000_0000, 32'h8000_0000, 5'd4);
		issue_single(rv32m_mul_pkg::MUL_LO, 32'hffff_fffd, 32'h0000_0007, 5'd5);
		issue_single(rv32m_mul_pkg::MUL_LO, 32'h1234_5678, 32'h8765_4321, 5'd6);
	endtask

	task automatic signed_high_corners();
		cur_test = "mulh";
		issue_single(rv32m_mul_pkg::MULH, 32'h0000_0000, 32'hffff_ffff, 5'd7);
		issue_single(rv32m_mul_pkg::MULH, 32'h0000_0001, 32'hffff_ffff, 5'd8);
		issue_single(rv32m_mul_pkg::MULH, 32'hffff_ffff, 32'hffff_ffff, 5'd9);
		issue_single(rv32m_mul_pkg::MULH, 32'h8000_0000, 32'h8000_0000, 5'd10);
		issue_single(rv32m_mul_pkg::MULH, 32'h8000_0000, 32'h7fff_ffff, 5'd11);
		issue_single(rv32m_mul_pkg::MULH, 32'hffff_fffd, 32'h1234_5678, 5'd12);
	endtask

	// Top bit set on either side exercises the unsigned correction
	task automatic unsigned_high_corners();
		cur_test = "mulhsu_mulhu";
		issue_single(rv32m_mul_pkg::MULHSU, 32'h8000_0000, 32'hffff_ffff, 5'd13);
		issue_single(rv32m_mul_pkg::MULHSU, 32'hffff_ffff, 32'h8000_0001, 5'd14);
		issue_single(rv32m_mul_pkg::MULHSU, 32'h7fff_ffff, 32'hffff_ffff, 5'd15);
		issue_single(rv32m_mul_pkg::MULHSU, 32'h0000_0003, 32'h8000_0000, 5'd16);
		issue_single(rv32m_mul_pkg::MULHU, 32'hffff_ffff, 32'hffff_ffff, 5'd17);
		issue_single(rv32m_mul_pkg::MULHU, 32'h8000_0000, 32'h8000_0000, 5'd18);
		issue_single(rv32m_mul_pkg::MULHU, 32'h0000_0002, 32'hc000_0000, 5'd19);
		issue_single(rv32m_mul_pkg::MULHU, 32'hdead_beef, 32'h0000_1000, 5'd20);
	endtask

	// Back-to-back issue with item i done on sample i+LATENCY
	task automatic random_stream();
		logic [`MUL_TAG_W-1:0] exp_tag [STREAM_LEN];
		logic [31:0] exp_res [STREAM_LEN];
		int d;
		int nd;
		cur_test = "stream";
		for (int j = 0; j <= STREAM_LEN + `MUL_LATENCY; j++) begin
			@(negedge CLK);
			if (j > 0) begin
				d = j - `MUL_LATENCY;
				nd = j - `MUL_LATENCY + 1;
				check("done", (d >= 0 && d < STREAM_LEN), done);
				check("next_done", (nd >= 0 && nd < STREAM_LEN), next_done);
				if (d >= 0 && d < STREAM_LEN) begin
					check("done_tag", exp_tag[d], done_tag);
					check("result", exp_res[d], result);
				end
				if (nd >= 0 && nd < STREAM_LEN)
					check("next_tag", exp_tag[nd], next_tag);
			end
			if (j < STREAM_LEN) begin
				valid = 1'b1;
				op = rv32m_mul_pkg::mul_op_t'($urandom_range(0, 3));
				rs1 = $urandom;
				rs2 = $urandom;
				tag = $urandom;
				exp_tag[j] = tag;
				exp_res[j] = model_result(op, rs1, rs2);
			end else begin
				valid = 1'b0;
			end
		end
	endtask

	initial begin
		cycle_count = 0;
		void'($urandom(88));
		nRST = 1'b0;
		valid = 1'b0;
		op = rv32m_mul_pkg::MUL_LO;
		rs1 = '0;
		rs2 = '0;
		tag = '0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		idle_quiet();
		low_word_corners();
		signed_high_corners();
		unsigned_high_corners();
		random_stream();
		$display("Everything OK");
		$finish;
	end

endmodule

/* list.f */
+incdir+include
verilog/rv32m_mul_pkg.sv
verilog/mul_csa.sv
verilog/multiplier.sv
verilog/mul_unit.sv
dv/mul_unit_tb.sv
